/* logic/limn_pkg.sv */
package limn_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int       NUM_REGS = 32;
    localparam reg_idx_t REG_LR   = 5'd31;      // JAL link register
    localparam word_t    RESET_PC = 32'hFFFE0000;

    // Code 0 is LUI in the immediate form and NOR in the register form.
    // Load/store forms reuse ADD to mark the register-indexed sum and
    // OR for the immediate-offset sum
    typedef enum logic [2:0] {
        ALU_LUI_NOR = 3'd0,
        ALU_OR      = 3'd1,
        ALU_XOR     = 3'd2,
        ALU_AND     = 3'd3,
        ALU_SLTS    = 3'd4,
        ALU_SLT     = 3'd5,
        ALU_SUB     = 3'd6,
        ALU_ADD     = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_LSL = 2'd0,
        SH_LSR = 2'd1,
        SH_ASR = 2'd2,
        SH_ROR = 2'd3
    } shift_e;

    typedef enum logic [3:0] {
        NOP, ALU_IMM, ALU_REG, BEQ, BNE, BLT, JAL, JALR, LOAD, STORE, HALT
    } inst_class_e;

    typedef enum logic [2:0] {
        S_FETCH, S_EXECUTE, S_READ, S_WRITE, S_HALT
    } cpu_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Low opcode patterns, matched in this order by the decoder
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [5:0] OPC_NOP          = 6'b000000;
    localparam logic [5:0] OPC_JALR         = 6'b111000;
    localparam logic [5:0] OPC_JAL          = 6'b000110;  // xxx11x
    localparam logic [5:0] OPC_JAL_CARE     = 6'b000110;
    localparam logic [5:0] OPC_BEQ          = 6'b111101;
    localparam logic [5:0] OPC_BNE          = 6'b110101;
    localparam logic [5:0] OPC_BLT          = 6'b101101;
    localparam logic [5:0] OPC_ALU_IMM      = 6'b000100;  // xxx100
    localparam logic [5:0] OPC_ALU_IMM_CARE = 6'b000111;
    localparam logic [5:0] OPC_LOAD         = 6'b100011;  // 1xx011
    localparam logic [5:0] OPC_LOAD_CARE    = 6'b100111;
    localparam logic [5:0] OPC_STORE        = 6'b000010;  // xx?010, bit 3 picks the data
    localparam logic [5:0] OPC_STORE_CARE   = 6'b000111;
    localparam logic [5:0] OPC_REG_GRP      = 6'b111001;
    localparam logic [5:0] OPC_PRIV         = 6'b101001;
    localparam logic [3:0] PRIV_HLT         = 4'b1100;    // High bits 31:28

endpackage

/* logic/limn_decode_if.sv */
interface limn_decode_if;
    import limn_pkg::*;

    inst_class_e  cls;
    reg_idx_t     rd;
    reg_idx_t     ra;
    reg_idx_t     rb;
    alu_op_e      alu_op;
    shift_e       shift_mode;
    logic [4:0]   shamt;
    logic [15:0]  imm16;
    logic [20:0]  imm21;
    logic [28:0]  imm29;
    logic         link;        // JAL writes r31
    logic         store_imm;   // Store data is the 5-bit immediate

    modport decoder (
        output cls, rd, ra, rb, alu_op, shift_mode, shamt,
        output imm16, imm21, imm29, link, store_imm
    );
    modport ctrl (
        input cls, rd, ra, rb, alu_op, shift_mode, shamt,
        input imm16, imm21, imm29, link, store_imm
    );
    modport alu (input alu_op, shift_mode, shamt, imm16, cls);

endinterface

/* logic/limn_decoder.sv */
module limn_decoder (
    input  limn_pkg::word_t inst,
    limn_decode_if.decoder  dec
);
    import limn_pkg::*;

    logic [5:0] opc;
    logic [3:0] grp;

    function automatic logic opc_is(
        input logic [5:0] op,
        input logic [5:0] pat,
        input logic [5:0] care
    );
        return (op & care) == pat;
    endfunction

    assign opc = inst[5:0];
    assign grp = inst[31:28];

    // Fixed field positions
    assign dec.rd         = inst[10:6];
    assign dec.ra         = inst[15:11];
    assign dec.rb         = inst[20:16];
    assign dec.shamt      = inst[25:21];
    assign dec.shift_mode = shift_e'(inst[27:26]);
    assign dec.imm16      = inst[31:16];
    assign dec.imm21      = inst[31:11];
    assign dec.imm29      = inst[31:3];
    assign dec.link       = inst[0];

    // First match wins
    always_comb begin
        dec.cls       = NOP;
        dec.alu_op    = alu_op_e'(opc[5:3]);
        dec.store_imm = 1'b0;
        if (opc == OPC_NOP) begin
            dec.cls = NOP;
        end else if (opc == OPC_JALR) begin
            dec.cls = JALR;
        end else if (opc_is(opc, OPC_JAL, OPC_JAL_CARE)) begin
            dec.cls = JAL;
        end else if (opc == OPC_BEQ) begin
            dec.cls = BEQ;
        end else if (opc == OPC_BNE) begin
            dec.cls = BNE;
        end else if (opc == OPC_BLT) begin
            dec.cls = BLT;
        end else if (opc_is(opc, OPC_ALU_IMM, OPC_ALU_IMM_CARE)) begin
            dec.cls = ALU_IMM;                  // Op from bits 5:3
        end else if (opc_is(opc, OPC_LOAD, OPC_LOAD_CARE)) begin
            dec.cls    = LOAD;
            dec.alu_op = ALU_OR;
        end else if (opc_is(opc, OPC_STORE, OPC_STORE_CARE)) begin
            dec.cls       = STORE;
            dec.alu_op    = ALU_OR;
            dec.store_imm = ~opc[3];
        end else if (opc == OPC_REG_GRP) begin
            casez (grp)
                4'b0000: begin
                    dec.cls    = ALU_REG;
                    dec.alu_op = ALU_LUI_NOR;   // NOR
                end
                4'b11??: begin
                    dec.cls    = STORE;
                    dec.alu_op = ALU_ADD;       // Indexed
                end
                4'b10??: begin
                    dec.cls    = LOAD;
                    dec.alu_op = ALU_ADD;
                end
                default: begin
                    dec.cls    = ALU_REG;
                    dec.alu_op = alu_op_e'(grp[2:0]);
                end
            endcase
        end else if (opc == OPC_PRIV && grp == PRIV_HLT) begin
            dec.cls = HALT;
        end
    end

endmodule

/* logic/limn_alu.sv */
module limn_alu (
    limn_decode_if.alu      dec,
    input  limn_pkg::word_t a,
    input  limn_pkg::word_t b,
    output limn_pkg::word_t result
);
    import limn_pkg::*;

    word_t       shifted;
    word_t       operand;
    word_t       offset;
    word_t       base;
    logic [63:0] rot;
    logic        indexed;

    assign rot = {b, b} >> dec.shamt;           // Rotate by zero gives b back

    always_comb begin
        case (dec.shift_mode)
            SH_LSR:  shifted = b >> dec.shamt;
            SH_ASR:  shifted = word_t'($signed(b) >>> dec.shamt);
            SH_ROR:  shifted = rot[31:0];
            default: shifted = b << dec.shamt;
        endcase
    end

    assign operand = (dec.cls == ALU_IMM) ? {16'b0, dec.imm16} : shifted;

    // Address sums, offsets in words
    assign indexed = (dec.alu_op == ALU_ADD);
    assign offset  = indexed ? shifted : {16'b0, dec.imm16};
    assign base    = (dec.cls == STORE && !indexed) ? b : a;  // Stores index off rd

    always_comb begin
        if (dec.cls == LOAD || dec.cls == STORE) begin
            result = base + {offset[29:0], 2'b00};
        end else begin
            case (dec.alu_op)
                ALU_ADD:  result = a + operand;
                ALU_SUB:  result = a - operand;
                ALU_AND:  result = a & operand;
                ALU_XOR:  result = a ^ operand;
                ALU_OR:   result = a | operand;
                ALU_SLT:  result = {31'b0, a < operand};
                ALU_SLTS: result = {31'b0, $signed(a) < $signed(operand)};
                default: begin
                    if (dec.cls == ALU_IMM) begin
                        result = a | {dec.imm16, 16'b0};   // LUI
                    end else begin
                        result = ~(a | operand);           // NOR
                    end
                end
            endcase
        end
    end

endmodule

/* logic/limn_regfile.sv */
module limn_regfile (
    input  logic               clk,
    input  logic               rst,
    input  limn_pkg::reg_idx_t raddr_a,
    input  limn_pkg::reg_idx_t raddr_b,
    output limn_pkg::word_t    rdata_a,
    output limn_pkg::word_t    rdata_b,
    input  logic               we,
    input  limn_pkg::reg_idx_t waddr,
    input  limn_pkg::word_t    wdata
);
    import limn_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // Combinational read ports
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

/* logic/limn_control.sv */
module limn_control (
    input  logic               clk,
    input  logic               rst,
    limn_decode_if.ctrl        dec,
    input  limn_pkg::word_t    data_in,
    input  logic               rdy,
    input  limn_pkg::word_t    alu_result,
    input  limn_pkg::word_t    rdata_a,
    input  limn_pkg::word_t    rdata_b,
    output limn_pkg::word_t    inst,
    output limn_pkg::reg_idx_t store_sel,
    output logic               rf_we,
    output limn_pkg::reg_idx_t rf_waddr,
    output limn_pkg::word_t    rf_wdata,
    output limn_pkg::word_t    addr,
    output limn_pkg::word_t    data_out,
    output logic               we,
    output logic               cs,
    output logic               halted
);
    import limn_pkg::*;

    cpu_state_e state;
    word_t      pc;             // Address of the instruction in execute
    word_t      rd_val;         // regs[rd], read while the instruction arrives
    word_t      link_pc;
    word_t      br_target;
    word_t      jalr_target;
    word_t      pc_next;
    word_t      st_data;
    logic       indexed;
    logic       br_taken;

    assign link_pc     = pc + 32'd4;
    assign indexed     = (dec.alu_op == ALU_ADD);
    assign br_target   = pc + {{9{dec.imm21[20]}}, dec.imm21, 2'b00};
    assign jalr_target = rdata_a + {{14{dec.imm16[15]}}, dec.imm16, 2'b00};
    assign halted      = (state == S_HALT);

    ////////////////////////////////////////////////////////////////////////////
    // Next PC
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (dec.cls)
            BEQ:     br_taken = (rd_val == '0);
            BNE:     br_taken = (rd_val != '0);
            BLT:     br_taken = rd_val[31];
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (dec.cls == JAL) begin
            pc_next = {pc[31], dec.imm29, 2'b00};   // Stays in the same half
        end else if (dec.cls == JALR) begin
            pc_next = jalr_target;
        end else if (br_taken) begin
            pc_next = br_target;
        end else begin
            pc_next = link_pc;
        end
    end

    // Second read port: rd of the incoming word during fetch
    always_comb begin
        if (state == S_FETCH) begin
            store_sel = data_in[10:6];
        end else if (dec.cls == STORE && !indexed) begin
            store_sel = dec.rd;                     // Base of an offset store
        end else begin
            store_sel = dec.rb;
        end
    end

    always_comb begin
        if (dec.store_imm) begin
            st_data = {27'b0, dec.ra};              // imm5 sits in the ra field
        end else if (indexed) begin
            st_data = rd_val;
        end else begin
            st_data = rdata_a;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register write port
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rf_we    = 1'b0;
        rf_waddr = dec.rd;
        rf_wdata = alu_result;
        if (state == S_EXECUTE) begin
            case (dec.cls)
                ALU_IMM, ALU_REG: rf_we = 1'b1;
                JAL: begin
                    rf_we    = dec.link;
                    rf_waddr = REG_LR;
                    rf_wdata = link_pc;
                end
                JALR: begin
                    rf_we    = 1'b1;
                    rf_wdata = link_pc;
                end
                default: rf_we = 1'b0;
            endcase
        end else if (state == S_READ) begin
            rf_we    = rdy;                         // Load lands with rdy
            rf_wdata = data_in;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // State machine and bus
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_FETCH;
            pc    <= RESET_PC;
            addr  <= RESET_PC;
            cs    <= 1'b1;
            we    <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (rdy) begin
                        state <= S_EXECUTE;
                        cs    <= 1'b0;
                    end
                end
                S_EXECUTE: begin
                    pc <= pc_next;
                    case (dec.cls)
                        LOAD: begin
                            state <= S_READ;
                            addr  <= alu_result;
                            cs    <= 1'b1;
                        end
                        STORE: begin
                            state <= S_WRITE;
                            addr  <= alu_result;
                            cs    <= 1'b1;
                            we    <= 1'b1;
                        end
                        HALT: state <= S_HALT;
                        default: begin
                            state <= S_FETCH;
                            addr  <= pc_next;
                            cs    <= 1'b1;
                        end
                    endcase
                end
                S_READ, S_WRITE: begin
                    if (rdy) begin
                        state <= S_FETCH;
                        addr  <= pc;                // Already the next PC
                        we    <= 1'b0;
                    end
                end
                default: begin                      // Halted for good
                    cs <= 1'b0;
                    we <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && rdy) begin
            inst   <= data_in;
            rd_val <= rdata_b;
        end
        if (state == S_EXECUTE && dec.cls == STORE) begin
            data_out <= st_data;
        end
    end

endmodule

/* logic/limn_cpu.sv */
module limn_cpu (
    input  logic            clk,
    input  logic            rst,
    output limn_pkg::word_t addr,
    input  limn_pkg::word_t data_in,
    output limn_pkg::word_t data_out,
    input  logic            rdy,
    output logic            we,
    output logic            cs,
    output logic            halted
);
    import limn_pkg::*;

    limn_decode_if dec_if ();

    word_t    inst;
    word_t    alu_result;
    word_t    rdata_a;
    word_t    rdata_b;
    word_t    rf_wdata;
    reg_idx_t store_sel;
    reg_idx_t rf_waddr;
    logic     rf_we;

    limn_decoder u_decoder (
        .inst (inst),
        .dec  (dec_if.decoder)
    );

    limn_alu u_alu (
        .dec    (dec_if.alu),
        .a      (rdata_a),
        .b      (rdata_b),
        .result (alu_result)
    );

    // Port b address is steered by the control block
    limn_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (dec_if.ra),
        .raddr_b (store_sel),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    limn_control u_control (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec_if.ctrl),
        .data_in    (data_in),
        .rdy        (rdy),
        .alu_result (alu_result),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b),
        .inst       (inst),
        .store_sel  (store_sel),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .addr       (addr),
        .data_out   (data_out),
        .we         (we),
        .cs         (cs),
        .halted     (halted)
    );

endmodule

/* test/limn_clock.sv */
module limn_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;   // Period of 8

endmodule

/* test/limn_cpu_chk.sv */
module limn_cpu_chk (
    input logic            clk,
    input logic            rst,
    input logic            cs,
    input logic            we,
    input logic            rdy,
    input logic            halted,
    input limn_pkg::word_t addr
);

    // A write strobe only starts together with chip select
    we_needs_cs: assert property (@(posedge clk) disable iff (rst) $rose(we) |-> cs)
        else $error("we rose while cs was low");

    // Bus held until the memory answers
    bus_stable: assert property (@(posedge clk) disable iff (rst)
        (cs && !rdy) |=> ($stable(addr) && $stable(we)))
        else $error("addr or we changed during a pending transfer");

    halt_idle: assert property (@(posedge clk) disable iff (rst) halted |-> !cs)
        else $error("cs high while halted");

endmodule

/* test/limn_tb.sv */
module limn_tb;
    import limn_pkg::*;

    localparam int CYCLE_LIMIT = 6 * 40 * 10;   // Tests x instructions x cycles
    localparam int DATA_BASE   = 128;           // Word index of address 0x200

    logic  clk;
    logic  rst;
    logic  rdy     = 1'b0;
    word_t data_in = '0;
    word_t addr;
    word_t data_out;
    logic  we;
    logic  cs;
    logic  halted;

    word_t       mem [1024];
    word_t       image [1024];                 // Copied into mem during reset
    word_t       write_addrs [$];
    logic [31:0] rng      = 32'd30;
    logic [1:0]  wait_cnt = '0;
    int          cycles   = 0;
    int          pc_idx;
    int          word_errors = 0;
    int          addr_errors = 0;
    int          flag_errors = 0;

    limn_clock u_clock (.clk(clk));

    limn_cpu DUT (
        .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .data_out(data_out),
        .rdy(rdy), .we(we), .cs(cs), .halted(halted)
    );

    bind limn_control limn_cpu_chk u_chk (
        .clk(clk), .rst(rst), .cs(cs), .we(we), .rdy(rdy), .halted(halted), .addr(addr)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t fill_word(input int idx);
        return 32'hC0DE0000 | word_t'(idx);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Memory with 0 to 3 wait states per transfer
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= image[i];
            end
            rdy      <= 1'b0;
            wait_cnt <= '0;
            write_addrs.delete();
        end else if (rdy) begin                // Transfer completes here
            if (we) begin
                mem[addr[11:2]] <= data_out;
                write_addrs.push_back(addr);
            end
            rdy      <= 1'b0;
            rng      <= xorshift(rng);
            wait_cnt <= rng[1:0];
        end else if (cs) begin
            if (wait_cnt == 0) begin
                rdy     <= 1'b1;
                data_in <= mem[addr[11:2]];
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the CPU did not halt within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            word_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            addr_errors++;
            $display("FAILED %s: expected address %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Instruction encoders
    function automatic word_t alu_imm(alu_op_e op, reg_idx_t rd, reg_idx_t ra,
                                      logic [15:0] imm);
        return {imm, ra, rd, op, 3'b100};
    endfunction

    function automatic word_t alu_reg(logic [3:0] grp, shift_e mode, logic [4:0] shamt,
                                      reg_idx_t rb, reg_idx_t ra, reg_idx_t rd);
        return {grp, mode, shamt, rb, ra, rd, 6'b111001};
    endfunction

    function automatic word_t store_word(reg_idx_t base, reg_idx_t src, logic [15:0] off);
        return {off, src, base, 6'b001010};
    endfunction

    function automatic word_t store_imm5(reg_idx_t base, logic [4:0] val, logic [15:0] off);
        return {off, val, base, 6'b000010};
    endfunction

    function automatic word_t load_word(reg_idx_t rd, reg_idx_t base, logic [15:0] off);
        return {off, base, rd, 6'b100011};
    endfunction

    function automatic word_t branch(logic [5:0] opc, reg_idx_t rd, int words);
        logic [20:0] off;
        off = 21'(words);
        return {off, rd, opc};
    endfunction

    function automatic word_t jump_link(word_t target, logic link);
        return {target[30:2], 2'b11, link};
    endfunction

    function automatic word_t jump_reg(reg_idx_t rd, reg_idx_t ra, logic [15:0] off);
        return {off, ra, rd, 6'b111000};
    endfunction

    function automatic word_t halt_word();
        return {4'b1100, 22'b0, 6'b101001};
    endfunction

    function automatic word_t pc_of(input int idx);
        return RESET_PC + word_t'(4 * idx);
    endfunction

    function automatic word_t result(input int k);
        return mem[DATA_BASE + k];
    endfunction

    task automatic new_program();
        for (int i = 0; i < 1024; i++) begin
            image[i] = fill_word(i);
        end
        pc_idx = 0;
    endtask

    task automatic emit(input word_t w);
        image[pc_idx] = w;
        pc_idx++;
    endtask

    task automatic run_program(input string name);
        @(posedge clk);
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_addr({name, ".reset_addr"}, RESET_PC, addr);
        check_flag({name, ".reset_cs"}, 1'b1, cs);
        check_flag({name, ".reset_we"}, 1'b0, we);
        check_flag({name, ".reset_halted"}, 1'b0, halted);
        while (!halted) begin
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_alu_imm();
        new_program();
        emit(alu_imm(ALU_ADD, 1, 0, 16'h0200));
        emit(alu_imm(ALU_ADD, 2, 0, 16'h1234));
        emit(alu_imm(ALU_LUI_NOR, 3, 0, 16'h8000));
        emit(alu_imm(ALU_OR, 3, 3, 16'h0005));
        emit(alu_imm(ALU_SUB, 4, 2, 16'h0034));
        emit(alu_imm(ALU_AND, 5, 2, 16'h00F0));
        emit(alu_imm(ALU_XOR, 6, 2, 16'hFFFF));
        emit(alu_imm(ALU_SLT, 7, 2, 16'h2000));
        emit(alu_imm(ALU_SLT, 8, 3, 16'h0001));   // Unsigned compare with a big value
        emit(alu_imm(ALU_SLTS, 9, 3, 16'h0001));  // Negative below one
        emit(alu_imm(ALU_SLTS, 10, 2, 16'h0001));
        emit(alu_imm(ALU_ADD, 0, 0, 16'h0055));   // r0 must ignore this
        for (int r = 0; r <= 10; r++) begin
            emit(store_word(1, r[4:0], r[15:0]));
        end
        emit(halt_word());
        run_program("alu_imm");
        check_word("alu_imm.r0", 32'h0, result(0));
        check_word("alu_imm.addi", 32'h200, result(1));
        check_word("alu_imm.addi2", 32'h1234, result(2));
        check_word("alu_imm.lui_ori", 32'h80000005, result(3));
        check_word("alu_imm.subi", 32'h1234 - 32'h34, result(4));
        check_word("alu_imm.andi", 32'h1234 & 32'hF0, result(5));
        check_word("alu_imm.xori", 32'h1234 ^ 32'hFFFF, result(6));
        check_word("alu_imm.slti_true", 32'd1, result(7));
        check_word("alu_imm.slti_false", 32'd0, result(8));
        check_word("alu_imm.sltis_neg", 32'd1, result(9));
        check_word("alu_imm.sltis_pos", 32'd0, result(10));
    endtask

    task automatic test_alu_reg();
        new_program();
        emit(alu_imm(ALU_ADD, 1, 0, 16'h0200));
        emit(alu_imm(ALU_ADD, 2, 0, 16'h1234));
        emit(alu_imm(ALU_LUI_NOR, 3, 0, 16'hF000));
        emit(alu_imm(ALU_OR, 3, 3, 16'h0010));
        emit(alu_reg(4'b0111, SH_LSL, 4, 3, 2, 4));
        emit(alu_reg(4'b0110, SH_LSR, 4, 3, 2, 5));
        emit(alu_reg(4'b0010, SH_ASR, 4, 3, 2, 6));
        emit(alu_reg(4'b0001, SH_ROR, 8, 3, 2, 7));
        emit(alu_reg(4'b0011, SH_ROR, 0, 3, 2, 8));
        emit(alu_reg(4'b0101, SH_LSL, 0, 3, 2, 9));
        emit(alu_reg(4'b0100, SH_LSL, 0, 3, 2, 10));
        emit(alu_reg(4'b0000, SH_LSL, 0, 3, 2, 11));
        emit(alu_reg(4'b0111, SH_ASR, 31, 3, 0, 12));
        for (int r = 4; r <= 12; r++) begin
            emit(store_word(1, r[4:0], r[15:0]));
        end
        emit(halt_word());
        run_program("alu_reg");
        check_word("alu_reg.add_lsl", 32'h1234 + (32'hF0000010 << 4), result(4));
        check_word("alu_reg.sub_lsr", 32'h1234 - (32'hF0000010 >> 4), result(5));
        check_word("alu_reg.xor_asr", 32'h1234 ^ 32'hFF000001, result(6));
        check_word("alu_reg.or_ror", 32'h1234 | 32'h10F00000, result(7));
        check_word("alu_reg.and_ror0", 32'h1234 & 32'hF0000010, result(8));
        check_word("alu_reg.slt", 32'd1, result(9));
        check_word("alu_reg.slts", 32'd0, result(10));
        check_word("alu_reg.nor", ~(32'h1234 | 32'hF0000010), result(11));
        check_word("alu_reg.asr31", 32'hFFFFFFFF, result(12));
    endtask

    task automatic test_branches();
        new_program();
        emit(alu_imm(ALU_ADD, 1, 0, 16'h0200));
        emit(alu_imm(ALU_ADD, 3, 0, 16'd5));
        emit(alu_imm(ALU_SUB, 4, 0, 16'd1));     // r4 negative
        emit(branch(OPC_BEQ, 2, 2));             // Taken
        emit(store_imm5(1, 9, 0));
        emit(store_imm5(1, 1, 1));
        emit(branch(OPC_BEQ, 3, 2));             // Not taken
        emit(store_imm5(1, 2, 2));
        emit(branch(OPC_BNE, 3, 2));
        emit(store_imm5(1, 9, 0));
        emit(branch(OPC_BNE, 2, 2));
        emit(store_imm5(1, 3, 3));
        emit(branch(OPC_BLT, 4, 4));             // Forward to index 16
        emit(store_imm5(1, 5, 5));
        emit(branch(OPC_BLT, 3, 3));
        emit(halt_word());
        emit(store_imm5(1, 4, 4));
        emit(branch(OPC_BEQ, 0, -4));            // Backward to index 13
        run_program("branch");
        check_word("branch.skipped", fill_word(DATA_BASE), result(0));
        for (int k = 1; k <= 5; k++) begin
            check_word($sformatf("branch.marker%0d", k), word_t'(k), result(k));
        end
    endtask

    task automatic test_jumps();
        new_program();
        emit(alu_imm(ALU_ADD, 1, 0, 16'h0200));
        emit(jump_link(pc_of(3), 1'b0));
        emit(store_imm5(1, 9, 0));
        emit(store_word(1, 31, 3));
        emit(jump_link(pc_of(8), 1'b1));
        emit(store_imm5(1, 9, 0));
        emit(store_word(1, 2, 2));
        emit(halt_word());
        emit(store_word(1, 31, 1));
        emit(jump_reg(2, 31, 16'd1));            // Back to index 6
        run_program("jump");
        check_word("jump.skipped", fill_word(DATA_BASE), result(0));
        check_word("jump.jal_link", pc_of(4) + 32'd4, result(1));
        check_word("jump.jalr_link", pc_of(9) + 32'd4, result(2));
        check_word("jump.no_link", 32'h0, result(3));
    endtask

    task automatic test_load_store();
        new_program();
        emit(alu_imm(ALU_ADD, 1, 0, 16'h0200));
        emit(alu_imm(ALU_ADD, 2, 0, 16'h4321));
        emit(store_word(1, 2, 4));
        emit(load_word(3, 1, 4));
        emit(store_word(1, 3, 5));
        emit(alu_imm(ALU_ADD, 4, 0, 16'd3));
        emit(alu_reg(4'b1100, SH_LSL, 1, 4, 1, 2));   // Indexed store of r2
        emit(alu_reg(4'b1000, SH_LSL, 1, 4, 1, 5));   // Indexed load into r5
        emit(alu_imm(ALU_ADD, 5, 5, 16'd1));
        emit(store_word(1, 5, 7));
        emit(store_imm5(1, 31, 8));
        emit(halt_word());
        run_program("ldst");
        check_word("ldst.store", 32'h4321, result(4));
        check_word("ldst.roundtrip", 32'h4321, result(5));
        check_word("ldst.indexed_store", 32'h4321, result(6));
        check_word("ldst.indexed_load", 32'h4322, result(7));
        check_word("ldst.imm5", 32'd31, result(8));
        check_word("ldst.write_count", 32'd5, word_t'(write_addrs.size()));
        if (write_addrs.size() == 5) begin
            for (int k = 0; k < 5; k++) begin
                check_addr($sformatf("ldst.write%0d", k), 32'h210 + word_t'(4 * k),
                           write_addrs[k]);
            end
        end
    endtask

    task automatic test_halt();
        new_program();
        emit(alu_imm(ALU_ADD, 1, 0, 16'h0200));
        emit(alu_imm(ALU_ADD, 2, 0, 16'd7));
        emit({16'hFFFF, 5'd2, 5'd2, 6'b000001});  // Unknown opcode
        emit({4'b0000, 22'h3FFFFF, 6'b101001});   // Dropped privileged form
        emit(store_word(1, 2, 0));
        emit(halt_word());
        emit(store_imm5(1, 9, 1));
        run_program("halt");
        check_word("halt.unknown_op", 32'd7, result(0));
        repeat (20) begin
            @(negedge clk);
            check_flag("halt.cs_low", 1'b0, cs);
            check_flag("halt.halted", 1'b1, halted);
        end
        check_word("halt.after_halt", fill_word(DATA_BASE + 1), result(1));
    endtask

    initial begin
        rst = 1'b1;
        test_alu_imm();
        test_alu_reg();
        test_branches();
        test_jumps();
        test_load_store();
        test_halt();
        $display("Errors: %0d data, %0d address, %0d flag", word_errors, addr_errors,
                 flag_errors);
        if (word_errors + addr_errors + flag_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/limn_pkg.sv
logic/limn_decode_if.sv
logic/limn_decoder.sv
logic/limn_alu.sv
logic/limn_regfile.sv
logic/limn_control.sv
logic/limn_cpu.sv
test/limn_clock.sv
test/limn_cpu_chk.sv
test/limn_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= limn_tb
BUILD     ?= build
LOG       ?= sim.log
FLIST     ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FLIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
